// File: controlUnit.f
source/armCtrlPkg.sv
source/instrDecoder.sv
source/condLogic.sv
source/controlUnit.sv
sim/controlUnit_chk.sv
sim/controlUnit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= controlUnit_tb
FILELIST  ?= controlUnit.f
OBJDIR    ?= obj_dir
PASSMSG   := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASSMSG)"; then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJDIR)

// File: sim/controlUnit_tb.sv
`timescale 1ns/1ps

module controlUnit_tb;

  logic                    clk = 1'b0;
  logic                    reset;
  armCtrlPkg::instrFieldsT instr;
  armCtrlPkg::aluFlagsT    aluFlags;
  armCtrlPkg::ctrlOutT     ctrl;

  armCtrlPkg::aluFlagsT modelFlags;
  armCtrlPkg::ctrlOutT  expCtrl;
  integer               seed;
  int                   errorCount = 0;
  int                   checkCount = 0;
  int                   testCount = 0;
  int                   testErrStart = 0;
  int                   testChkStart = 0;
  int                   cycleCount = 0;
  int                   cycleLimit = 1000;

  controlUnit i_controlUnit (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .aluFlags (aluFlags),
    .ctrl     (ctrl)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run stopped after %0d cycles before the tests finished", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

  function automatic armCtrlPkg::instrFieldsT makeDp(input logic [3:0] cond, input logic imm,
                                                     input logic [3:0] cmd, input logic s,
                                                     input logic [3:0] rd);
    armCtrlPkg::instrFieldsT ins;
    ins.dpView.cond    = cond;
    ins.dpView.op      = armCtrlPkg::opDp;
    ins.dpView.immFlag = imm;
    ins.dpView.cmd     = cmd;
    ins.dpView.sBit    = s;
    ins.dpView.rn      = 4'd1;
    ins.dpView.rd      = rd;
    return ins;
  endfunction

  function automatic armCtrlPkg::instrFieldsT makeMem(input logic [3:0] cond, input logic l,
                                                      input logic [3:0] rd);
    armCtrlPkg::instrFieldsT ins;
    ins = '0;
    ins.memView.cond = cond;
    ins.memView.op   = armCtrlPkg::opMem;
    ins.memView.p    = 1'b1;
    ins.memView.u    = 1'b1;
    ins.memView.l    = l;
    ins.memView.rn   = 4'd2;
    ins.memView.rd   = rd;
    return ins;
  endfunction

  function automatic armCtrlPkg::instrFieldsT makeBranch(input logic [3:0] cond);
    armCtrlPkg::instrFieldsT ins;
    ins = armCtrlPkg::instrFieldsT'(20'h0a5c3);
    ins.dpView.cond = cond;
    ins.dpView.op   = armCtrlPkg::opBranch;
    return ins;
  endfunction

  // Pairs of codes share a base test and odd codes invert it
  function automatic logic condPasses(input logic [3:0] cond, input armCtrlPkg::aluFlagsT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = (f.n == f.v) & ~f.z;
      default: base = 1'b1;
    endcase
    return (cond == 4'b1111) ? 1'b0 : (base ^ cond[0]);
  endfunction

  function automatic armCtrlPkg::ctrlOutT expectCtrl(input armCtrlPkg::instrFieldsT ins,
                                                     input armCtrlPkg::aluFlagsT f);
    armCtrlPkg::ctrlOutT e;
    logic pass;
    logic wantReg;
    logic wantBranch;
    e          = '0;
    wantReg    = 1'b0;
    wantBranch = 1'b0;
    pass       = condPasses(ins.dpView.cond, f);
    if (ins.dpView.op == armCtrlPkg::opDp) begin
      e.aluSrc = ins.dpView.immFlag;
      wantReg  = 1'b1;
      if (ins.dpView.cmd == armCtrlPkg::cmdSub) e.aluControl = armCtrlPkg::aluSub;
      if (ins.dpView.cmd == armCtrlPkg::cmdAnd) e.aluControl = armCtrlPkg::aluAnd;
      if (ins.dpView.cmd == armCtrlPkg::cmdOrr) e.aluControl = armCtrlPkg::aluOrr;
    end else if (ins.dpView.op == armCtrlPkg::opMem) begin
      e.immSrc   = armCtrlPkg::immMem;
      e.aluSrc   = 1'b1;
      e.memToReg = ins.memView.l;
      wantReg    = ins.memView.l;
      e.memWrite = ~ins.memView.l & pass;
      e.regSrc   = ins.memView.l ? 2'b00 : 2'b10;
    end else begin
      e.regSrc   = 2'b01;
      e.immSrc   = armCtrlPkg::immBranch;
      e.aluSrc   = 1'b1;
      wantBranch = 1'b1;
    end
    e.regWrite = wantReg & pass;
    e.pcSrc    = (wantBranch | (wantReg & (ins.dpView.rd == 4'd15))) & pass;
    return e;
  endfunction

  task automatic reportField(input string name);
    $display("error at %0t ns: instr %h field %s wrong, ctrl %h expected %h",
             $time, instr, name, ctrl, expCtrl);
    errorCount = errorCount + 1;
  endtask

  task automatic checkCtrl;
    expCtrl    = expectCtrl(instr, modelFlags);
    checkCount = checkCount + 1;
    assert (ctrl.regSrc == expCtrl.regSrc) else reportField("regSrc");
    assert (ctrl.regWrite == expCtrl.regWrite) else reportField("regWrite");
    assert (ctrl.immSrc == expCtrl.immSrc) else reportField("immSrc");
    assert (ctrl.aluSrc == expCtrl.aluSrc) else reportField("aluSrc");
    assert (ctrl.aluControl == expCtrl.aluControl) else reportField("aluControl");
    assert (ctrl.memWrite == expCtrl.memWrite) else reportField("memWrite");
    assert (ctrl.memToReg == expCtrl.memToReg) else reportField("memToReg");
    assert (ctrl.pcSrc == expCtrl.pcSrc) else reportField("pcSrc");
  endtask

  // Model copy of the status flags that loads at the coming edge
  task automatic updateModelFlags;
    logic isArith;
    logic isLogic;
    isArith = (instr.dpView.cmd == armCtrlPkg::cmdAdd) || (instr.dpView.cmd == armCtrlPkg::cmdSub);
    isLogic = (instr.dpView.cmd == armCtrlPkg::cmdAnd) || (instr.dpView.cmd == armCtrlPkg::cmdOrr);
    if (instr.dpView.op == armCtrlPkg::opDp && instr.dpView.sBit &&
        condPasses(instr.dpView.cond, modelFlags)) begin
      if (isArith) modelFlags = aluFlags;
      if (isLogic) begin
        modelFlags.n = aluFlags.n;
        modelFlags.z = aluFlags.z;
      end
    end
  endtask

  task automatic applyInstr(input armCtrlPkg::instrFieldsT ins, input armCtrlPkg::aluFlagsT f);
    @(posedge clk);
    instr    <= ins;
    aluFlags <= f;
    @(negedge clk);
    checkCtrl();
    updateModelFlags();
  endtask

  task automatic pulseReset;
    @(posedge clk);
    reset <= 1'b1;
    instr <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    modelFlags = '0;
  endtask

  task automatic startTest;
    testErrStart = errorCount;
    testChkStart = checkCount;
  endtask

  task automatic endTest(input string name);
    testCount = testCount + 1;
    $display("test %s: %0d checks, %0d errors", name, checkCount - testChkStart,
             errorCount - testErrStart);
  endtask

  initial begin
    armCtrlPkg::aluFlagsT    f;
    armCtrlPkg::instrFieldsT ins;
    logic [31:0]             r;
    logic [3:0]              cmds [4];
    armCtrlPkg::aluFlagsT    condStates [3];

    // Reset twice, directed tests, condition sweep, then random instructions
    cycleLimit = 2 * (5 + 8 + 2 + 2 + 9 + 3 * 33 + 200 + 1 + 6 + 2);
    seed       = 32'hbcad_9b29;
    modelFlags = '0;
    reset      = 1'b1;
    instr      = '0;
    aluFlags   = '0;
    cmds       = '{armCtrlPkg::cmdAdd, armCtrlPkg::cmdSub, armCtrlPkg::cmdAnd,
                   armCtrlPkg::cmdOrr};
    condStates = '{4'b0000, 4'b1010, 4'b1111};
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    startTest();
    for (int i = 0; i < 8; i++) begin
      applyInstr(makeDp(armCtrlPkg::condAl, i[0], cmds[i / 2], 1'b0, 4'd3), 4'b0000);
    end
    endTest("dpDecode");

    startTest();
    applyInstr(makeMem(armCtrlPkg::condAl, 1'b0, 4'd4), 4'b0000);
    applyInstr(makeMem(armCtrlPkg::condAl, 1'b1, 4'd5), 4'b0000);
    endTest("memDecode");

    startTest();
    applyInstr(makeBranch(armCtrlPkg::condAl), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condAl, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd15), 4'b0000);
    endTest("pcRedirect");

    startTest();
    applyInstr(makeDp(armCtrlPkg::condAl, 1'b0, armCtrlPkg::cmdSub, 1'b1, 4'd1), 4'b1010);
    applyInstr(makeDp(armCtrlPkg::condMi, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condCs, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condAl, 1'b1, armCtrlPkg::cmdAnd, 1'b1, 4'd2), 4'b0101);
    applyInstr(makeDp(armCtrlPkg::condEq, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condCs, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condVs, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condAl, 1'b0, armCtrlPkg::cmdSub, 1'b0, 4'd1), 4'b1111);
    applyInstr(makeDp(armCtrlPkg::condMi, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    endTest("flagUpdate");

    // Three flag states so that every code except AL fails at least once
    startTest();
    foreach (condStates[s]) begin
      applyInstr(makeDp(armCtrlPkg::condAl, 1'b0, armCtrlPkg::cmdAdd, 1'b1, 4'd1),
                 condStates[s]);
      for (int c = 0; c < 16; c++) begin
        applyInstr(makeDp(c[3:0], 1'b1, armCtrlPkg::cmdOrr, 1'b0, 4'd15), 4'b0000);
        applyInstr(makeMem(c[3:0], c[0], 4'd6), 4'b0000);
      end
    end
    endTest("condSuppress");

    startTest();
    for (int i = 0; i < 200; i++) begin
      r   = $random(seed);
      ins = armCtrlPkg::instrFieldsT'(r[19:0]);
      ins.dpView.op = 2'($unsigned(r[23:20]) % 3);
      f   = armCtrlPkg::aluFlagsT'(r[27:24]);
      applyInstr(ins, f);
    end
    endTest("random");

    startTest();
    applyInstr(makeDp(armCtrlPkg::condAl, 1'b0, armCtrlPkg::cmdAdd, 1'b1, 4'd1), 4'b0100);
    pulseReset();
    applyInstr(makeDp(armCtrlPkg::condEq, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    applyInstr(makeDp(armCtrlPkg::condNe, 1'b0, armCtrlPkg::cmdAdd, 1'b0, 4'd1), 4'b0000);
    endTest("reset");

    $display("summary: %0d tests, %0d checks, %0d errors, %0d bound assertion failures",
             testCount, checkCount, errorCount, i_controlUnit.i_condLogic.i_condChk.failCount);
    if (errorCount == 0 && i_controlUnit.i_condLogic.i_condChk.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sim/controlUnit_chk.sv
`timescale 1ns/1ps

module controlUnit_chk (
  input logic                clk,
  input logic                reset,
  input logic [3:0]          cond,
  input logic [1:0]          nzFlags,
  input armCtrlPkg::ctrlOutT ctrl
);

  int   failCount = 0;
  logic condFails;

  // Never code, and EQ or NE against the stored Z in bit 0
  assign condFails = (cond == armCtrlPkg::condNever) ||
                     (cond == armCtrlPkg::condEq && !nzFlags[0]) ||
                     (cond == armCtrlPkg::condNe && nzFlags[0]);

  // A store never writes the register file
  noDoubleWrite: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.memWrite && ctrl.regWrite))
    else begin
      $error("memWrite and regWrite are both set");
      failCount++;
    end

  loadUsesImm: assert property (@(posedge clk) disable iff (reset)
    ctrl.memToReg |-> ctrl.aluSrc)
    else begin
      $error("memToReg is set without aluSrc");
      failCount++;
    end

  failBlocksWrites: assert property (@(posedge clk) disable iff (reset)
    condFails |-> (!ctrl.regWrite && !ctrl.memWrite && !ctrl.pcSrc))
    else begin
      $error("a write control is set while the condition fails");
      failCount++;
    end

endmodule

bind condLogic controlUnit_chk i_condChk (
  .clk     (clk),
  .reset   (reset),
  .cond    (cond),
  .nzFlags (nzFlags),
  .ctrl    (ctrl)
);

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic                    clk,
  input  logic                    reset,
  input  armCtrlPkg::instrFieldsT instr,
  input  armCtrlPkg::aluFlagsT    aluFlags,
  output armCtrlPkg::ctrlOutT     ctrl
);

  armCtrlPkg::rawCtrlT raw;

  // Decode stage, no state
  instrDecoder i_instrDecoder (
    .instr (instr),
    .raw   (raw)
  );

  // Condition check and status flags
  condLogic i_condLogic (
    .clk      (clk),
    .reset    (reset),
    .cond     (instr.dpView.cond),
    .aluFlags (aluFlags),
    .raw      (raw),
    .ctrl     (ctrl)
  );

endmodule

// File: source/condLogic.sv
`timescale 1ns/1ps

module condLogic (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [3:0]           cond,
  input  armCtrlPkg::aluFlagsT aluFlags,
  input  armCtrlPkg::rawCtrlT  raw,
  output armCtrlPkg::ctrlOutT  ctrl
);

  logic [1:0] nzFlags;
  logic [1:0] cvFlags;
  logic       n;
  logic       z;
  logic       c;
  logic       v;
  logic       condEx;
  logic [1:0] flagEn;

  assign {n, z} = nzFlags;
  assign {c, v} = cvFlags;

  // Condition check against the stored flags
  always_comb begin
    case (cond)
      armCtrlPkg::condEq:    condEx = z;
      armCtrlPkg::condNe:    condEx = ~z;
      armCtrlPkg::condCs:    condEx = c;
      armCtrlPkg::condCc:    condEx = ~c;
      armCtrlPkg::condMi:    condEx = n;
      armCtrlPkg::condPl:    condEx = ~n;
      armCtrlPkg::condVs:    condEx = v;
      armCtrlPkg::condVc:    condEx = ~v;
      armCtrlPkg::condHi:    condEx = c & ~z;
      armCtrlPkg::condLs:    condEx = ~c | z;
      armCtrlPkg::condGe:    condEx = (n == v);
      armCtrlPkg::condLt:    condEx = (n != v);
      armCtrlPkg::condGt:    condEx = ~z & (n == v);
      armCtrlPkg::condLe:    condEx = z | (n != v);
      armCtrlPkg::condAl:    condEx = 1'b1;
      armCtrlPkg::condNever: condEx = 1'b0;
      default:               condEx = 1'b0;
    endcase
  end

  // Flags only load when the instruction itself executes
  assign flagEn = raw.flagWrite & {2{condEx}};

  always_ff @(posedge clk) begin
    if (reset) begin
      nzFlags <= 2'b00;
    end else if (flagEn[1]) begin
      nzFlags <= {aluFlags.n, aluFlags.z};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cvFlags <= 2'b00;
    end else if (flagEn[0]) begin
      cvFlags <= {aluFlags.c, aluFlags.v};
    end
  end

  // Write-type controls are suppressed on a failed condition
  assign ctrl = '{
    regSrc:     raw.regSrc,
    regWrite:   raw.regWriteReq & condEx,
    immSrc:     raw.immSrc,
    aluSrc:     raw.aluSrc,
    aluControl: raw.aluControl,
    memWrite:   raw.memWriteReq & condEx,
    memToReg:   raw.memToReg,
    pcSrc:      raw.pcs & condEx
  };

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  armCtrlPkg::instrFieldsT instr,
  output armCtrlPkg::rawCtrlT     raw
);

  logic [1:0] op;
  logic [1:0] regSrc;
  logic [1:0] immSrc;
  logic       aluSrc;
  logic       memToReg;
  logic       regWriteReq;
  logic       memWriteReq;
  logic       branch;
  logic       aluOp;
  logic [1:0] aluControl;
  logic [1:0] flagWrite;
  logic       pcs;

  // Op sits at the same place in both views
  assign op = instr.dpView.op;

  // Main decoder
  always_comb begin
    regSrc      = 2'b00;
    immSrc      = armCtrlPkg::immDp;
    aluSrc      = 1'b0;
    memToReg    = 1'b0;
    regWriteReq = 1'b0;
    memWriteReq = 1'b0;
    branch      = 1'b0;
    aluOp       = 1'b0;

    case (op)
      armCtrlPkg::opDp: begin
        aluSrc      = instr.dpView.immFlag;
        immSrc      = armCtrlPkg::immDp;
        regWriteReq = 1'b1;
        aluOp       = 1'b1;
      end

      armCtrlPkg::opMem: begin
        immSrc = armCtrlPkg::immMem;
        aluSrc = 1'b1;
        if (instr.memView.l) begin
          // LDR
          memToReg    = 1'b1;
          regWriteReq = 1'b1;
        end else begin
          // STR reads rd as the store data register
          regSrc      = 2'b10;
          memWriteReq = 1'b1;
        end
      end

      armCtrlPkg::opBranch: begin
        regSrc = 2'b01;
        immSrc = armCtrlPkg::immBranch;
        aluSrc = 1'b1;
        branch = 1'b1;
      end

      default: begin
        // Op 11 is not supported, no side effects
        regSrc = 2'b00;
      end
    endcase
  end

  // ALU decoder
  always_comb begin
    aluControl = armCtrlPkg::aluAdd;
    flagWrite  = 2'b00;

    if (aluOp) begin
      case (instr.dpView.cmd)
        armCtrlPkg::cmdAdd: begin
          aluControl = armCtrlPkg::aluAdd;
          flagWrite  = {2{instr.dpView.sBit}};
        end

        armCtrlPkg::cmdSub: begin
          aluControl = armCtrlPkg::aluSub;
          flagWrite  = {2{instr.dpView.sBit}};
        end

        // Logic ops leave C and V alone
        armCtrlPkg::cmdAnd: begin
          aluControl = armCtrlPkg::aluAnd;
          flagWrite  = {instr.dpView.sBit, 1'b0};
        end

        armCtrlPkg::cmdOrr: begin
          aluControl = armCtrlPkg::aluOrr;
          flagWrite  = {instr.dpView.sBit, 1'b0};
        end

        default: begin
          aluControl = armCtrlPkg::aluAdd;
          flagWrite  = 2'b00;
        end
      endcase
    end
  end

  // PC written by a branch or by any register write to R15
  assign pcs = branch | (regWriteReq & (instr.dpView.rd == armCtrlPkg::pcReg));

  assign raw = '{
    regSrc:      regSrc,
    immSrc:      immSrc,
    aluControl:  aluControl,
    aluSrc:      aluSrc,
    memToReg:    memToReg,
    regWriteReq: regWriteReq,
    memWriteReq: memWriteReq,
    branch:      branch,
    pcs:         pcs,
    flagWrite:   flagWrite
  };

endmodule

// File: source/armCtrlPkg.sv
package armCtrlPkg;

  // Instruction slice seen by the control unit, bits 31 down to 12
  localparam int instrWidth = 20;

  localparam int condWidth = 4;
  localparam int opWidth   = 2;
  localparam int cmdWidth  = 4;
  localparam int regWidth  = 4;

  // Op field
  localparam logic [opWidth-1:0] opDp     = 2'b00;
  localparam logic [opWidth-1:0] opMem    = 2'b01;
  localparam logic [opWidth-1:0] opBranch = 2'b10;

  // Data-processing commands kept by the ALU decoder
  localparam logic [cmdWidth-1:0] cmdAdd = 4'b0100;
  localparam logic [cmdWidth-1:0] cmdSub = 4'b0010;
  localparam logic [cmdWidth-1:0] cmdAnd = 4'b0000;
  localparam logic [cmdWidth-1:0] cmdOrr = 4'b1100;

  // Condition codes
  localparam logic [condWidth-1:0] condEq    = 4'b0000;
  localparam logic [condWidth-1:0] condNe    = 4'b0001;
  localparam logic [condWidth-1:0] condCs    = 4'b0010;
  localparam logic [condWidth-1:0] condCc    = 4'b0011;
  localparam logic [condWidth-1:0] condMi    = 4'b0100;
  localparam logic [condWidth-1:0] condPl    = 4'b0101;
  localparam logic [condWidth-1:0] condVs    = 4'b0110;
  localparam logic [condWidth-1:0] condVc    = 4'b0111;
  localparam logic [condWidth-1:0] condHi    = 4'b1000;
  localparam logic [condWidth-1:0] condLs    = 4'b1001;
  localparam logic [condWidth-1:0] condGe    = 4'b1010;
  localparam logic [condWidth-1:0] condLt    = 4'b1011;
  localparam logic [condWidth-1:0] condGt    = 4'b1100;
  localparam logic [condWidth-1:0] condLe    = 4'b1101;
  localparam logic [condWidth-1:0] condAl    = 4'b1110;
  localparam logic [condWidth-1:0] condNever = 4'b1111;

  // ALU operation select
  localparam logic [1:0] aluAdd = 2'b00;
  localparam logic [1:0] aluSub = 2'b01;
  localparam logic [1:0] aluAnd = 2'b10;
  localparam logic [1:0] aluOrr = 2'b11;

  // Immediate extension select
  localparam logic [1:0] immDp     = 2'b00;
  localparam logic [1:0] immMem    = 2'b01;
  localparam logic [1:0] immBranch = 2'b10;

  localparam logic [regWidth-1:0] pcReg = 4'd15;

  typedef struct packed {
    logic [condWidth-1:0] cond;
    logic [opWidth-1:0]   op;
    logic                 immFlag;
    logic [cmdWidth-1:0]  cmd;
    logic                 sBit;
    logic [regWidth-1:0]  rn;
    logic [regWidth-1:0]  rd;
  } dpViewT;

  // Bit 25 is inverted for memory: 0 means immediate offset
  typedef struct packed {
    logic [condWidth-1:0] cond;
    logic [opWidth-1:0]   op;
    logic                 nonImm;
    logic                 p;
    logic                 u;
    logic                 b;
    logic                 w;
    logic                 l;
    logic [regWidth-1:0]  rn;
    logic [regWidth-1:0]  rd;
  } memViewT;

  typedef union packed {
    dpViewT  dpView;
    memViewT memView;
  } instrFieldsT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } aluFlagsT;

  // Decoder output before condition gating
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic [1:0] aluControl;
    logic       aluSrc;
    logic       memToReg;
    logic       regWriteReq;
    logic       memWriteReq;
    logic       branch;
    logic       pcs;
    logic [1:0] flagWrite;  // [1] N and Z, [0] C and V
  } rawCtrlT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic       regWrite;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic [1:0] aluControl;
    logic       memWrite;
    logic       memToReg;
    logic       pcSrc;
  } ctrlOutT;

endpackage
